// File: source/otp_emu_pkg.sv
/*
 * OTP emulator shared definitions
 * Command and error encodings plus the word and interface widths
 * used by the dispatcher, the banks and the response collector
 */
package otp_emu_pkg;

  ////////////////////
  // Widths
  ////////////////////

  // Native OTP word
  localparam int WordWidth = 16;
  // Size field holds the number of words minus one
  localparam int SizeWidth = 2;
  localparam int MaxWords  = 2 ** SizeWidth;
  // Interface data carries up to MaxWords native words
  localparam int IfWidth   = MaxWords * WordWidth;

  ////////////////////
  // Encodings
  ////////////////////

  // Command opcodes accepted at the command port
  typedef enum logic [1:0] {
    OtpInit  = 2'd0,
    OtpRead  = 2'd1,
    OtpWrite = 2'd2
  } otp_cmd_e;

  // Response status
  // Cmd error is a Read or Write to a bank still waiting for Init
  typedef enum logic [1:0] {
    OtpNoError         = 2'd0,
    OtpCmdError        = 2'd1,
    OtpWriteBlankError = 2'd2
  } otp_err_e;

endpackage

// File: source/otp_cmd_dispatch.sv
/*
 * OTP command dispatcher
 * Accepts external commands, keeps one credit counter per bank and
 * registers each accepted command onto the bank bus with a one-hot push
 */
`timescale 1ns/10ps

module otp_cmd_dispatch #(
  parameter  int NumBanks   = 4,
  parameter  int BankDepth  = 256,
  parameter  int QueueDepth = 2,
  localparam int AddrWidth  = $clog2(NumBanks) + $clog2(BankDepth)
) (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  // External command port
  input  logic                                cmd_valid_i,
  output logic                                cmd_ready_o,
  input  otp_emu_pkg::otp_cmd_e               cmd_i,
  input  logic [otp_emu_pkg::SizeWidth-1:0]   size_i,
  input  logic [AddrWidth-1:0]                addr_i,
  input  logic [otp_emu_pkg::IfWidth-1:0]     wdata_i,
  // Credit return, one pulse per popped command
  input  logic [NumBanks-1:0]                 credit_i,
  // Broadcast bus to the banks
  output logic [NumBanks-1:0]                 bank_push_o,
  output otp_emu_pkg::otp_cmd_e               bank_cmd_o,
  output logic [otp_emu_pkg::SizeWidth-1:0]   bank_size_o,
  output logic [AddrWidth-1:0]                bank_addr_o,
  output logic [otp_emu_pkg::IfWidth-1:0]     bank_wdata_o
);

  import otp_emu_pkg::*;

  localparam int BankBits = $clog2(NumBanks);
  localparam int CntW     = $clog2(QueueDepth + 1);

  logic [CntW-1:0]     credit_q [NumBanks];
  logic                loaded_q;
  logic [BankBits-1:0] bank_sel;
  logic                accept;
  logic [NumBanks-1:0] push_sel;

  // Bank index sits in the upper address bits
  assign bank_sel = addr_i[AddrWidth-1 -: BankBits];

  // Held low for the cycle in which the credits load
  assign cmd_ready_o = loaded_q && (credit_q[bank_sel] != '0);
  assign accept      = cmd_valid_i && cmd_ready_o;
  assign push_sel    = accept ? (NumBanks'(1) << bank_sel) : '0;

  ////////////////////
  // Credit counters
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_credit
    if (!rst_ni) begin
      loaded_q <= 1'b0;
      for (int b = 0; b < NumBanks; b++) begin
        credit_q[b] <= '0;
      end
    end else if (!loaded_q) begin
      loaded_q <= 1'b1;
      for (int b = 0; b < NumBanks; b++) begin
        credit_q[b] <= CntW'(QueueDepth);
      end
    end else begin
      // Push and return in the same cycle cancel out
      for (int b = 0; b < NumBanks; b++) begin
        if (push_sel[b] && !credit_i[b]) begin
          credit_q[b] <= credit_q[b] - 1'b1;
        end else if (credit_i[b] && !push_sel[b]) begin
          credit_q[b] <= credit_q[b] + 1'b1;
        end
      end
    end
  end

  ////////////////////
  // Bank bus
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_push
    if (!rst_ni) begin
      bank_push_o <= '0;
    end else begin
      bank_push_o <= push_sel;
    end
  end

  // Payload only moves on an accepted command
  always_ff @(posedge clk_i) begin : p_bus
    if (accept) begin
      bank_cmd_o   <= cmd_i;
      bank_size_o  <= size_i;
      bank_addr_o  <= addr_i;
      bank_wdata_o <= wdata_i;
    end
  end

endmodule

// File: source/otp_bank_emu.sv
/*
 * Emulated OTP bank
 * Command FIFO, control FSM and storage array. Writes go through a
 * read-modify-write so that bits can only be set, never cleared
 */
`timescale 1ns/10ps

module otp_bank_emu #(
  parameter  int NumBanks   = 4,
  parameter  int BankDepth  = 256,
  parameter  int QueueDepth = 2,
  localparam int AddrWidth  = $clog2(NumBanks) + $clog2(BankDepth)
) (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  // Command push from the dispatcher, never refused
  input  logic                                push_i,
  input  otp_emu_pkg::otp_cmd_e               cmd_i,
  input  logic [otp_emu_pkg::SizeWidth-1:0]   size_i,
  input  logic [AddrWidth-1:0]                addr_i,
  input  logic [otp_emu_pkg::IfWidth-1:0]     wdata_i,
  output logic                                credit_o,
  // Response, held until granted
  input  logic                                rsp_grant_i,
  output logic                                rsp_valid_o,
  output logic [otp_emu_pkg::IfWidth-1:0]     rsp_rdata_o,
  output otp_emu_pkg::otp_err_e               rsp_err_o,
  output logic [AddrWidth-1:0]                rsp_addr_o
);

  import otp_emu_pkg::*;

  localparam int WordBits = $clog2(BankDepth);
  localparam int PtrW     = (QueueDepth > 1) ? $clog2(QueueDepth) : 1;
  localparam int FillW    = $clog2(QueueDepth + 1);

  typedef enum logic [2:0] {
    ResetSt, IdleSt, ReadSt, ReadWaitSt, WriteCheckSt, WriteWaitSt, WriteSt, RspHoldSt
  } otp_bank_state_e;

  ////////////////////
  // Command FIFO
  ////////////////////

  otp_cmd_e             fifo_cmd_q   [QueueDepth];
  logic [SizeWidth-1:0] fifo_size_q  [QueueDepth];
  logic [AddrWidth-1:0] fifo_addr_q  [QueueDepth];
  logic [IfWidth-1:0]   fifo_wdata_q [QueueDepth];
  logic [PtrW-1:0]      wptr_q, rptr_q;
  logic [FillW-1:0]     fill_q;
  logic                 fifo_empty;
  logic                 pop;
  otp_cmd_e             head_cmd;

  assign fifo_empty = (fill_q == '0);
  assign head_cmd   = fifo_cmd_q[rptr_q];
  // One credit goes back per popped entry
  assign credit_o   = pop;

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_fifo_ptr
    if (!rst_ni) begin
      wptr_q <= '0;
      rptr_q <= '0;
      fill_q <= '0;
    end else begin
      if (push_i) begin
        wptr_q <= (wptr_q == PtrW'(QueueDepth - 1)) ? '0 : wptr_q + 1'b1;
      end
      if (pop) begin
        rptr_q <= (rptr_q == PtrW'(QueueDepth - 1)) ? '0 : rptr_q + 1'b1;
      end
      if (push_i && !pop) begin
        fill_q <= fill_q + 1'b1;
      end else if (pop && !push_i) begin
        fill_q <= fill_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin : p_fifo_data
    if (push_i) begin
      fifo_cmd_q[wptr_q]   <= cmd_i;
      fifo_size_q[wptr_q]  <= size_i;
      fifo_addr_q[wptr_q]  <= addr_i;
      fifo_wdata_q[wptr_q] <= wdata_i;
    end
  end

  ////////////////////
  // Control FSM
  ////////////////////

  otp_bank_state_e state_d, state_q;
  otp_cmd_e        cmd_q;
  otp_err_e        err_q;
  logic [SizeWidth-1:0] cnt_q, size_q;
  logic [AddrWidth-1:0] addr_q;
  logic [MaxWords-1:0][WordWidth-1:0] wdata_q, rdata_q;
  logic [WordWidth-1:0] mem_rdata_q;
  logic [WordWidth-1:0] mem_q [BankDepth];
  logic [WordBits-1:0]  mem_addr;
  logic [WordWidth-1:0] mem_wdata;
  logic mem_re, mem_we, capture, cnt_en, cnt_clr, blank_err;

  always_comb begin : p_fsm
    state_d = state_q;
    pop     = 1'b0;
    mem_re  = 1'b0;
    mem_we  = 1'b0;
    capture = 1'b0;
    cnt_en  = 1'b0;
    cnt_clr = 1'b0;
    unique case (state_q)
      // Before Init only Init is served, anything else bounces with an error
      ResetSt, IdleSt: begin
        if (!fifo_empty) begin
          pop = 1'b1;
          if (state_q == ResetSt && head_cmd != OtpInit) begin
            state_d = RspHoldSt;
          end else if (head_cmd == OtpWrite) begin
            state_d = WriteCheckSt;
          end else begin
            state_d = ReadSt;
          end
        end
      end
      // Init has no storage access and answers from here
      ReadSt: begin
        if (cmd_q == OtpInit) begin
          state_d = RspHoldSt;
        end else begin
          mem_re  = 1'b1;
          state_d = ReadWaitSt;
        end
      end
      ReadWaitSt: begin
        capture = 1'b1;
        cnt_en  = 1'b1;
        state_d = (cnt_q == size_q) ? RspHoldSt : ReadSt;
      end
      // Old words are captured first for the blank check
      WriteCheckSt: begin
        mem_re  = 1'b1;
        state_d = WriteWaitSt;
      end
      WriteWaitSt: begin
        capture = 1'b1;
        if (cnt_q == size_q) begin
          cnt_clr = 1'b1;
          state_d = WriteSt;
        end else begin
          cnt_en  = 1'b1;
          state_d = WriteCheckSt;
        end
      end
      WriteSt: begin
        mem_we = 1'b1;
        cnt_en = 1'b1;
        if (cnt_q == size_q) begin
          state_d = RspHoldSt;
        end
      end
      // A bounced command leaves the bank waiting for Init
      RspHoldSt: begin
        if (rsp_grant_i) begin
          state_d = (cmd_q == OtpInit || err_q != OtpCmdError) ? IdleSt : ResetSt;
        end
      end
      default: state_d = ResetSt;
    endcase
  end

  // Setting only: stored word is old OR new
  assign blank_err = mem_we && |(rdata_q[cnt_q] & ~wdata_q[cnt_q]);
  assign mem_wdata = rdata_q[cnt_q] | wdata_q[cnt_q];
  // Word address wraps inside the bank
  assign mem_addr  = addr_q[WordBits-1:0] + WordBits'(cnt_q);

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_ctrl
    if (!rst_ni) begin
      state_q <= ResetSt;
      cmd_q   <= OtpInit;
      err_q   <= OtpNoError;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      if (pop) begin
        cmd_q <= head_cmd;
        err_q <= (state_q == ResetSt && head_cmd != OtpInit) ? OtpCmdError : OtpNoError;
        cnt_q <= '0;
      end else if (cnt_clr) begin
        cnt_q <= '0;
      end else if (cnt_en) begin
        cnt_q <= cnt_q + 1'b1;
      end
      if (blank_err) begin
        err_q <= OtpWriteBlankError;
      end
    end
  end

  // Unused upper words stay zero from the clear on pop
  always_ff @(posedge clk_i) begin : p_payload
    if (pop) begin
      size_q  <= fifo_size_q[rptr_q];
      addr_q  <= fifo_addr_q[rptr_q];
      wdata_q <= fifo_wdata_q[rptr_q];
      rdata_q <= '0;
    end else if (capture) begin
      rdata_q[cnt_q] <= mem_rdata_q;
    end
    if (mem_re) begin
      mem_rdata_q <= mem_q[mem_addr];
    end
  end

  ////////////////////
  // Storage
  ////////////////////

  // Blank OTP reads as all zeros
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_mem
    if (!rst_ni) begin
      for (int i = 0; i < BankDepth; i++) begin
        mem_q[i] <= '0;
      end
    end else if (mem_we) begin
      mem_q[mem_addr] <= mem_wdata;
    end
  end

  assign rsp_valid_o = (state_q == RspHoldSt);
  // rdata_q holds old words during a write, only reads return data
  assign rsp_rdata_o = (cmd_q == OtpRead) ? rdata_q : '0;
  assign rsp_err_o   = err_q;
  assign rsp_addr_o  = addr_q;

endmodule

// File: source/otp_rsp_collect.sv
/*
 * OTP response collector
 * Round-robin arbiter over the bank responses feeding one output register
 */
`timescale 1ns/10ps

module otp_rsp_collect #(
  parameter  int NumBanks  = 4,
  parameter  int BankDepth = 256,
  localparam int AddrWidth = $clog2(NumBanks) + $clog2(BankDepth)
) (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  // Bank side
  input  logic [NumBanks-1:0]               bank_valid_i,
  input  logic [otp_emu_pkg::IfWidth-1:0]   bank_rdata_i [NumBanks],
  input  otp_emu_pkg::otp_err_e             bank_err_i   [NumBanks],
  input  logic [AddrWidth-1:0]              bank_addr_i  [NumBanks],
  output logic [NumBanks-1:0]               rsp_grant_o,
  // External response port
  output logic                              rsp_valid_o,
  input  logic                              rsp_ready_i,
  output logic [otp_emu_pkg::IfWidth-1:0]   rsp_rdata_o,
  output otp_emu_pkg::otp_err_e             rsp_err_o,
  output logic [AddrWidth-1:0]              rsp_addr_o
);

  import otp_emu_pkg::*;

  localparam int IdxW = $clog2(NumBanks);

  logic [IdxW-1:0] last_q, gnt_idx;
  logic            gnt_found, can_load, gnt;

  // Output register is free or drains this cycle
  assign can_load = !rsp_valid_o || rsp_ready_i;
  assign gnt      = can_load && gnt_found;

  // Search starts one past the last granted bank
  always_comb begin : p_arb
    logic [IdxW-1:0] cand;
    gnt_idx   = last_q;
    gnt_found = 1'b0;
    for (int k = 1; k <= NumBanks; k++) begin
      cand = IdxW'(int'(last_q) + k);
      if (!gnt_found && bank_valid_i[cand]) begin
        gnt_found = 1'b1;
        gnt_idx   = cand;
      end
    end
  end

  assign rsp_grant_o = gnt ? (NumBanks'(1) << gnt_idx) : '0;

  ////////////////////
  // Output register
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_ctrl
    if (!rst_ni) begin
      rsp_valid_o <= 1'b0;
      last_q      <= '0;
    end else if (gnt) begin
      rsp_valid_o <= 1'b1;
      last_q      <= gnt_idx;
    end else if (rsp_ready_i) begin
      rsp_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin : p_data
    if (gnt) begin
      rsp_rdata_o <= bank_rdata_i[gnt_idx];
      rsp_err_o   <= bank_err_i[gnt_idx];
      rsp_addr_o  <= bank_addr_i[gnt_idx];
    end
  end

endmodule

// File: source/otp_emu_top.sv
/*
 * Banked OTP emulator top level
 * Dispatcher, NumBanks emulated banks and the response collector
 */
`timescale 1ns/10ps

module otp_emu_top #(
  parameter  int NumBanks   = 4,
  parameter  int BankDepth  = 256,
  parameter  int QueueDepth = 2,
  localparam int AddrWidth  = $clog2(NumBanks) + $clog2(BankDepth)
) (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  // Command port
  input  logic                              cmd_valid_i,
  output logic                              cmd_ready_o,
  input  otp_emu_pkg::otp_cmd_e             cmd_i,
  input  logic [otp_emu_pkg::SizeWidth-1:0] size_i,
  input  logic [AddrWidth-1:0]              addr_i,
  input  logic [otp_emu_pkg::IfWidth-1:0]   wdata_i,
  // Response port
  output logic                              rsp_valid_o,
  input  logic                              rsp_ready_i,
  output logic [otp_emu_pkg::IfWidth-1:0]   rsp_rdata_o,
  output otp_emu_pkg::otp_err_e             rsp_err_o,
  output logic [AddrWidth-1:0]              rsp_addr_o
);

  import otp_emu_pkg::*;

  // Broadcast bus and per-bank strobes
  logic [NumBanks-1:0]  bank_push, bank_credit, bank_valid, bank_grant;
  otp_cmd_e             bus_cmd;
  logic [SizeWidth-1:0] bus_size;
  logic [AddrWidth-1:0] bus_addr;
  logic [IfWidth-1:0]   bus_wdata;
  // Per-bank responses
  logic [IfWidth-1:0]   bank_rdata [NumBanks];
  otp_err_e             bank_err   [NumBanks];
  logic [AddrWidth-1:0] bank_addr  [NumBanks];

  otp_cmd_dispatch #(
    .NumBanks  (NumBanks),
    .BankDepth (BankDepth),
    .QueueDepth(QueueDepth)
  ) i_otp_cmd_dispatch (
    .clk_i,
    .rst_ni,
    .cmd_valid_i,
    .cmd_ready_o,
    .cmd_i,
    .size_i,
    .addr_i,
    .wdata_i,
    .credit_i    (bank_credit),
    .bank_push_o (bank_push),
    .bank_cmd_o  (bus_cmd),
    .bank_size_o (bus_size),
    .bank_addr_o (bus_addr),
    .bank_wdata_o(bus_wdata)
  );

  for (genvar b = 0; b < NumBanks; b++) begin : g_bank
    otp_bank_emu #(
      .NumBanks  (NumBanks),
      .BankDepth (BankDepth),
      .QueueDepth(QueueDepth)
    ) i_otp_bank_emu (
      .clk_i,
      .rst_ni,
      .push_i     (bank_push[b]),
      .cmd_i      (bus_cmd),
      .size_i     (bus_size),
      .addr_i     (bus_addr),
      .wdata_i    (bus_wdata),
      .rsp_grant_i(bank_grant[b]),
      .credit_o   (bank_credit[b]),
      .rsp_valid_o(bank_valid[b]),
      .rsp_rdata_o(bank_rdata[b]),
      .rsp_err_o  (bank_err[b]),
      .rsp_addr_o (bank_addr[b])
    );
  end

  otp_rsp_collect #(
    .NumBanks (NumBanks),
    .BankDepth(BankDepth)
  ) i_otp_rsp_collect (
    .clk_i,
    .rst_ni,
    .bank_valid_i(bank_valid),
    .bank_rdata_i(bank_rdata),
    .bank_err_i  (bank_err),
    .bank_addr_i (bank_addr),
    .rsp_grant_o (bank_grant),
    .rsp_valid_o,
    .rsp_ready_i,
    .rsp_rdata_o,
    .rsp_err_o,
    .rsp_addr_o
  );

endmodule

// File: include/otp_emu_vectors.svh
/*
 * OTP emulator directed vectors
 * Command, size, address and write data with the expected response
 */
`ifndef OTP_EMU_VECTORS_SVH
`define OTP_EMU_VECTORS_SVH

// Address is bank index in bits 9:8, word address below
typedef struct packed {
  otp_emu_pkg::otp_cmd_e cmd;
  logic [1:0]            size;
  logic [9:0]            addr;
  logic [63:0]           wdata;
  logic [63:0]           exp_rdata;
  otp_emu_pkg::otp_err_e exp_err;
} otp_vec_t;

localparam int NumVecs = 17;

localparam otp_vec_t OtpVecs [NumVecs] = '{
  // Read before Init, then Init and a read of blank storage
  '{otp_emu_pkg::OtpRead,  2'd0, 10'h010, 64'h0, 64'h0, otp_emu_pkg::OtpCmdError},
  '{otp_emu_pkg::OtpInit,  2'd0, 10'h000, 64'h0, 64'h0, otp_emu_pkg::OtpNoError},
  '{otp_emu_pkg::OtpRead,  2'd3, 10'h010, 64'h0, 64'h0, otp_emu_pkg::OtpNoError},
  '{otp_emu_pkg::OtpInit,  2'd0, 10'h100, 64'h0, 64'h0, otp_emu_pkg::OtpNoError},
  '{otp_emu_pkg::OtpInit,  2'd0, 10'h200, 64'h0, 64'h0, otp_emu_pkg::OtpNoError},
  '{otp_emu_pkg::OtpInit,  2'd0, 10'h300, 64'h0, 64'h0, otp_emu_pkg::OtpNoError},
  // Four-word write and read back, then a single word
  '{otp_emu_pkg::OtpWrite, 2'd3, 10'h010, 64'h4444_3333_2222_1111, 64'h0,
    otp_emu_pkg::OtpNoError},
  '{otp_emu_pkg::OtpRead,  2'd3, 10'h010, 64'h0, 64'h4444_3333_2222_1111,
    otp_emu_pkg::OtpNoError},
  '{otp_emu_pkg::OtpRead,  2'd0, 10'h012, 64'h0, 64'h3333, otp_emu_pkg::OtpNoError},
  // Clearing bit 0 of 0x1111 is a blank error, stored value is the OR
  '{otp_emu_pkg::OtpWrite, 2'd0, 10'h010, 64'h00F0, 64'h0,
    otp_emu_pkg::OtpWriteBlankError},
  '{otp_emu_pkg::OtpRead,  2'd0, 10'h010, 64'h0, 64'h11F1, otp_emu_pkg::OtpNoError},
  // Same low address in bank 1 is independent of bank 0
  '{otp_emu_pkg::OtpWrite, 2'd0, 10'h110, 64'hBEEF, 64'h0, otp_emu_pkg::OtpNoError},
  '{otp_emu_pkg::OtpRead,  2'd0, 10'h110, 64'h0, 64'hBEEF, otp_emu_pkg::OtpNoError},
  '{otp_emu_pkg::OtpRead,  2'd0, 10'h010, 64'h0, 64'h11F1, otp_emu_pkg::OtpNoError},
  // Write across the top of bank 2 wraps to its word 0
  '{otp_emu_pkg::OtpWrite, 2'd3, 10'h2FE, 64'hD004_C003_B002_A001, 64'h0,
    otp_emu_pkg::OtpNoError},
  '{otp_emu_pkg::OtpRead,  2'd1, 10'h200, 64'h0, 64'hD004_C003, otp_emu_pkg::OtpNoError},
  '{otp_emu_pkg::OtpRead,  2'd1, 10'h2FF, 64'h0, 64'hC003_B002, otp_emu_pkg::OtpNoError}
};

`endif

// File: tb/tb_otp_emu_top.sv
/*
 * Testbench for the banked OTP emulator
 * Directed vector table, then a random burst to all banks with
 * response back-pressure, checked against an OR-rule memory model
 */
`timescale 1ns/10ps

module tb_otp_emu_top;

  import otp_emu_pkg::*;

  `include "otp_emu_vectors.svh"

  localparam int NumBanks   = 4;
  localparam int BankDepth  = 256;
  localparam int QueueDepth = 2;
  localparam int AddrWidth  = 10;
  localparam int Timeout    = 200;
  localparam int NumRandom  = 64;

  // One expected response in command order
  typedef struct packed {
    logic [AddrWidth-1:0] addr;
    logic [IfWidth-1:0]   rdata;
    otp_err_e             err;
  } exp_rsp_t;

  logic                 clk_i;
  logic                 rst_ni;
  logic                 cmd_valid_i;
  logic                 cmd_ready_o;
  otp_cmd_e             cmd_i;
  logic [SizeWidth-1:0] size_i;
  logic [AddrWidth-1:0] addr_i;
  logic [IfWidth-1:0]   wdata_i;
  logic                 rsp_valid_o;
  logic                 rsp_ready_i;
  logic [IfWidth-1:0]   rsp_rdata_o;
  otp_err_e             rsp_err_o;
  logic [AddrWidth-1:0] rsp_addr_o;

  // Reference contents of all banks with the bank index in the upper part
  logic [WordWidth-1:0] model_mem [NumBanks*BankDepth];
  exp_rsp_t             pend_q [$];
  otp_cmd_e             rnd_cmd   [NumRandom];
  logic [SizeWidth-1:0] rnd_size  [NumRandom];
  logic [AddrWidth-1:0] rnd_addr  [NumRandom];
  logic [IfWidth-1:0]   rnd_wdata [NumRandom];
  int                   sent_cnt  [NumBanks];
  int                   done_cnt  [NumBanks];
  integer               seed;
  int                   errors;
  int                   test_errs;
  int                   tests_run;
  int                   tests_failed;
  int                   rsp_cnt;
  bit                   timed_out;
  bit                   issue_done;

  otp_emu_top #(
    .NumBanks  (NumBanks),
    .BankDepth (BankDepth),
    .QueueDepth(QueueDepth)
  ) i_otp_emu_top (
    .clk_i,
    .rst_ni,
    .cmd_valid_i,
    .cmd_ready_o,
    .cmd_i,
    .size_i,
    .addr_i,
    .wdata_i,
    .rsp_valid_o,
    .rsp_ready_i,
    .rsp_rdata_o,
    .rsp_err_o,
    .rsp_addr_o
  );

  initial clk_i = 1'b0;
  always #4 clk_i = ~clk_i;

  ////////////////////
  // Reference model
  ////////////////////

  // Word address wraps inside the addressed bank
  function automatic int model_index(input logic [AddrWidth-1:0] addr, input int k);
    return int'(addr[9:8]) * BankDepth + ((int'(addr[7:0]) + k) % BankDepth);
  endfunction

  // Reads return stored words and writes OR in the new words
  task automatic predict(input otp_cmd_e cmd, input logic [SizeWidth-1:0] size,
                         input logic [AddrWidth-1:0] addr, input logic [IfWidth-1:0] wdata,
                         output logic [IfWidth-1:0] rdata, output otp_err_e err);
    logic [WordWidth-1:0] old_w;
    logic [WordWidth-1:0] new_w;
    int                   idx;
    rdata = '0;
    err   = OtpNoError;
    for (int k = 0; k <= int'(size); k++) begin
      idx   = model_index(addr, k);
      old_w = model_mem[idx];
      new_w = wdata[k*WordWidth +: WordWidth];
      if (cmd == OtpRead) begin
        rdata[k*WordWidth +: WordWidth] = old_w;
      end else if (cmd == OtpWrite) begin
        // Old one bit against a new zero bit
        if ((old_w & ~new_w) != '0) begin
          err = OtpWriteBlankError;
        end
        model_mem[idx] = old_w | new_w;
      end
    end
  endtask

  ////////////////////
  // Bus helpers
  ////////////////////

  // Holds the command until accepted
  // Starts on a falling edge
  task automatic issue_cmd(input otp_cmd_e cmd, input logic [SizeWidth-1:0] size,
                           input logic [AddrWidth-1:0] addr, input logic [IfWidth-1:0] wdata,
                           output bit accepted);
    int waited;
    accepted    = 1'b0;
    waited      = 0;
    cmd_valid_i = 1'b1;
    cmd_i       = cmd;
    size_i      = size;
    addr_i      = addr;
    wdata_i     = wdata;
    while (!accepted && waited < Timeout) begin
      #2;
      if (cmd_ready_o) begin
        accepted = 1'b1;
      end
      @(negedge clk_i);
      waited++;
    end
    cmd_valid_i = 1'b0;
    if (!accepted) begin
      $display("Timeout at %0t: cmd_ready_o stayed low for address 0x%03h", $time, addr);
      timed_out = 1'b1;
      errors++;
      test_errs++;
    end
  endtask

  task automatic wait_rsp(output logic [IfWidth-1:0] rdata, output otp_err_e err,
                          output logic [AddrWidth-1:0] addr, output bit seen);
    int waited;
    seen        = 1'b0;
    waited      = 0;
    rsp_ready_i = 1'b1;
    while (!seen && waited < Timeout) begin
      #2;
      if (rsp_valid_o) begin
        seen  = 1'b1;
        rdata = rsp_rdata_o;
        err   = rsp_err_o;
        addr  = rsp_addr_o;
      end
      @(negedge clk_i);
      waited++;
    end
    if (!seen) begin
      $display("Timeout at %0t: no response came back on rsp_valid_o", $time);
      timed_out = 1'b1;
      errors++;
      test_errs++;
    end
  endtask

  task automatic check_response(input logic [IfWidth-1:0] got_rdata, input otp_err_e got_err,
                                input logic [AddrWidth-1:0] got_addr,
                                input logic [IfWidth-1:0] exp_rdata, input otp_err_e exp_err,
                                input logic [AddrWidth-1:0] exp_addr);
    if (got_rdata !== exp_rdata) begin
      $display("ERROR at %0t: rsp_rdata_o = 0x%016h, expected 0x%016h",
               $time, got_rdata, exp_rdata);
      errors++;
      test_errs++;
    end
    if (got_err !== exp_err) begin
      $display("ERROR at %0t: rsp_err_o = %s, expected %s",
               $time, got_err.name(), exp_err.name());
      errors++;
      test_errs++;
    end
    if (got_addr !== exp_addr) begin
      $display("ERROR at %0t: rsp_addr_o = 0x%03h, expected 0x%03h",
               $time, got_addr, exp_addr);
      errors++;
      test_errs++;
    end
  endtask

  task automatic report_test(input string name);
    tests_run++;
    if (test_errs != 0) begin
      tests_failed++;
      $display("Test %0d %s: failed with %0d errors", tests_run, name, test_errs);
    end else begin
      $display("Test %0d %s: passed", tests_run, name);
    end
  endtask

  ////////////////////
  // Directed table
  ////////////////////

  task automatic run_vectors();
    otp_vec_t             vec;
    logic [IfWidth-1:0]   unused_rdata;
    otp_err_e             unused_err;
    logic [IfWidth-1:0]   got_rdata;
    otp_err_e             got_err;
    logic [AddrWidth-1:0] got_addr;
    bit                   ok;
    bit                   seen;
    for (int v = 0; v < NumVecs && !timed_out; v++) begin
      vec       = OtpVecs[v];
      test_errs = 0;
      issue_cmd(vec.cmd, vec.size, vec.addr, vec.wdata, ok);
      if (ok) begin
        // Keeps the model in step for the random phase
        predict(vec.cmd, vec.size, vec.addr, vec.wdata, unused_rdata, unused_err);
        wait_rsp(got_rdata, got_err, got_addr, seen);
        if (seen) begin
          check_response(got_rdata, got_err, got_addr, vec.exp_rdata, vec.exp_err, vec.addr);
        end
      end
      report_test($sformatf("vector %0d %s addr 0x%03h", v, vec.cmd.name(), vec.addr));
    end
  endtask

  ////////////////////
  // Random burst
  ////////////////////

  // Stimulus drawn up front so only the drain process uses the seed later
  task automatic make_random();
    for (int n = 0; n < NumRandom; n++) begin
      rnd_cmd[n]   = ($random(seed) & 1) ? OtpWrite : OtpRead;
      rnd_size[n]  = SizeWidth'($random(seed));
      rnd_addr[n]  = AddrWidth'($random(seed));
      // Sparse data so that some writes pass the blank check
      rnd_wdata[n] = {$random(seed), $random(seed)} & {$random(seed), $random(seed)};
    end
  endtask

  task automatic issue_random();
    exp_rsp_t exp;
    bit       ok;
    int       b;
    for (int n = 0; n < NumRandom && !timed_out; n++) begin
      issue_cmd(rnd_cmd[n], rnd_size[n], rnd_addr[n], rnd_wdata[n], ok);
      if (ok) begin
        predict(rnd_cmd[n], rnd_size[n], rnd_addr[n], rnd_wdata[n], exp.rdata, exp.err);
        exp.addr = rnd_addr[n];
        pend_q.push_back(exp);
        b = int'(rnd_addr[n][9:8]);
        sent_cnt[b]++;
        // Queue entries, the busy bank slot and the collector register
        if (sent_cnt[b] - done_cnt[b] > QueueDepth + 2) begin
          $display("Bank %0d accepted a command at %0t beyond its credit limit", b, $time);
          errors++;
          test_errs++;
        end
      end
    end
    issue_done = 1'b1;
  endtask

  // Oldest pending entry of the same bank must match
  task automatic match_rsp(input logic [IfWidth-1:0] rdata, input otp_err_e err,
                           input logic [AddrWidth-1:0] addr);
    int idx;
    idx = -1;
    for (int i = 0; i < pend_q.size(); i++) begin
      if (idx < 0 && pend_q[i].addr[9:8] == addr[9:8]) begin
        idx = i;
      end
    end
    if (idx < 0) begin
      $display("Response at %0t from bank %0d with no command outstanding", $time, addr[9:8]);
      errors++;
      test_errs++;
    end else begin
      check_response(rdata, err, addr, pend_q[idx].rdata, pend_q[idx].err, pend_q[idx].addr);
      pend_q.delete(idx);
      done_cnt[addr[9:8]]++;
    end
  endtask

  task automatic drain_rsp();
    int idle;
    idle = 0;
    while (!(issue_done && pend_q.size() == 0) && idle < Timeout && !timed_out) begin
      @(negedge clk_i);
      rsp_ready_i = ($random(seed) & 3) != 0;
      #2;
      if (rsp_valid_o && rsp_ready_i) begin
        idle = 0;
        rsp_cnt++;
        match_rsp(rsp_rdata_o, rsp_err_o, rsp_addr_o);
      end else begin
        idle++;
      end
    end
    if (pend_q.size() != 0 || !issue_done) begin
      $display("Timeout at %0t: %0d responses still missing", $time, pend_q.size());
      timed_out = 1'b1;
      errors++;
      test_errs++;
    end
  endtask

  task automatic run_random();
    int sent_total;
    sent_total = 0;
    test_errs  = 0;
    make_random();
    fork
      issue_random();
      drain_rsp();
    join
    // No further response may show up
    @(negedge clk_i);
    rsp_ready_i = 1'b1;
    for (int c = 0; c < 20; c++) begin
      #2;
      if (rsp_valid_o) begin
        rsp_cnt++;
        $display("Extra response on rsp_valid_o at %0t after all commands", $time);
        errors++;
        test_errs++;
      end
      @(negedge clk_i);
    end
    for (int b = 0; b < NumBanks; b++) begin
      sent_total += sent_cnt[b];
    end
    if (rsp_cnt != sent_total) begin
      $display("ERROR at %0t: rsp_valid_o count = %0d, expected %0d",
               $time, rsp_cnt, sent_total);
      errors++;
      test_errs++;
    end
    report_test($sformatf("random burst of %0d commands", sent_total));
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    seed         = 32'ha1cb;
    errors       = 0;
    test_errs    = 0;
    tests_run    = 0;
    tests_failed = 0;
    rsp_cnt      = 0;
    timed_out    = 1'b0;
    issue_done   = 1'b0;
    rst_ni       = 1'b0;
    cmd_valid_i  = 1'b0;
    cmd_i        = OtpInit;
    size_i       = '0;
    addr_i       = '0;
    wdata_i      = '0;
    rsp_ready_i  = 1'b0;
    for (int i = 0; i < NumBanks * BankDepth; i++) begin
      model_mem[i] = '0;
    end
    for (int b = 0; b < NumBanks; b++) begin
      sent_cnt[b] = 0;
      done_cnt[b] = 0;
    end
    repeat (5) @(negedge clk_i);
    rst_ni = 1'b1;
    run_vectors();
    if (!timed_out) begin
      run_random();
    end
    $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// File: all.f
+incdir+include
source/otp_emu_pkg.sv
source/otp_cmd_dispatch.sv
source/otp_bank_emu.sv
source/otp_rsp_collect.sv
source/otp_emu_top.sv
tb/tb_otp_emu_top.sv

// File: Makefile
# Verilator build and run of the banked OTP emulator testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing -f all.f --top-module tb_otp_emu_top -Mdir obj_dir
	./obj_dir/Vtb_otp_emu_top | tee sim.log
	@if grep -q "TEST FAIL" sim.log; then \
		echo "Simulation reported a failure"; \
		exit 1; \
	fi
	@grep -q "TEST PASS" sim.log

clean:
	rm -rf obj_dir sim.log
